// ==== design/recovery_pkg.sv ====
// Recovery command layer shared types, command codes and register byte lengths
package recovery_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] word_t;
  typedef logic [15:0] len_t;

  // Recovery command codes handled by this device
  typedef enum logic [7:0] {
    CMD_PROT_CAP           = 8'd34,
    CMD_DEVICE_STATUS      = 8'd36,
    CMD_DEVICE_RESET       = 8'd37,
    CMD_RECOVERY_CTRL      = 8'd38,
    CMD_RECOVERY_STATUS    = 8'd39,
    CMD_INDIRECT_FIFO_DATA = 8'd47
  } command_e;

  // Protocol status codes, reported in DEVICE_STATUS byte 1
  typedef enum logic [7:0] {
    PROTOCOL_OK              = 8'h0,
    PROTOCOL_ERROR_READ_ONLY = 8'h1,
    PROTOCOL_ERROR_PARAMETER = 8'h2,
    PROTOCOL_ERROR_LENGTH    = 8'h3,
    PROTOCOL_ERROR_CRC       = 8'h4
  } protocol_error_e;

  // Register word selector
  typedef enum logic [3:0] {
    CSR_PROT_CAP_0      = 4'd0,
    CSR_PROT_CAP_1      = 4'd1,
    CSR_DEVICE_STATUS   = 4'd2,
    CSR_DEVICE_RESET    = 4'd3,
    CSR_RECOVERY_CTRL   = 4'd4,
    CSR_RECOVERY_STATUS = 4'd5,
    CSR_FIFO_DATA       = 4'd6,
    CSR_INVALID         = 4'hF
  } csr_e;

  // One parsed transaction
  typedef struct packed {
    logic            is_rd;
    command_e        cmd;
    len_t            len;
    protocol_error_e err;
  } recovery_cmd_t;

  // Register lengths in bytes
  localparam len_t PROT_CAP_LEN        = 16'd8;
  localparam len_t DEVICE_STATUS_LEN   = 16'd4;
  localparam len_t DEVICE_RESET_LEN    = 16'd3;
  localparam len_t RECOVERY_CTRL_LEN   = 16'd3;
  localparam len_t RECOVERY_STATUS_LEN = 16'd2;
  localparam len_t DEFAULT_LEN         = 16'd4;

  function automatic len_t cmd_length(command_e cmd);
    len_t len;
    case (cmd)
      CMD_PROT_CAP:        len = PROT_CAP_LEN;
      CMD_DEVICE_STATUS:   len = DEVICE_STATUS_LEN;
      CMD_DEVICE_RESET:    len = DEVICE_RESET_LEN;
      CMD_RECOVERY_CTRL:   len = RECOVERY_CTRL_LEN;
      CMD_RECOVERY_STATUS: len = RECOVERY_STATUS_LEN;
      default:             len = DEFAULT_LEN;
    endcase
    return len;
  endfunction

endpackage

// ==== design/recovery_cmd_parser.sv ====
// Command parser that turns bus transaction bytes into a command and a payload stream
`timescale 1ns/1ps

module recovery_cmd_parser (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        rx_start_i,
  input  logic                        rx_rd_i,
  input  logic                        rx_valid_i,
  input  recovery_pkg::byte_t         rx_byte_i,
  input  logic                        rx_end_i,
  input  logic                        rx_pec_err_i,
  output logic                        cmd_valid_o,
  output recovery_pkg::recovery_cmd_t cmd_o,
  output logic                        pl_valid_o,
  output recovery_pkg::byte_t         pl_byte_o,
  output logic                        pl_flush_o
);

  // Byte index saturates at 3, the first payload byte of a write
  logic [1:0]                      idx_q;
  recovery_pkg::len_t              pl_cnt_q;
  logic                            open_q;
  logic                            busy_q;
  logic                            take_pl;
  recovery_pkg::recovery_cmd_t     cmd_q;
  recovery_pkg::protocol_error_e   err_d;

  assign take_pl = rx_valid_i & open_q & ~cmd_q.is_rd & (idx_q == 2'd3);
  assign cmd_o   = cmd_q;

  // Frame check at rx_end
  always_comb begin
    err_d = recovery_pkg::PROTOCOL_OK;
    if (rx_pec_err_i) begin
      err_d = recovery_pkg::PROTOCOL_ERROR_CRC;
    end else if (idx_q == 2'd0) begin
      err_d = recovery_pkg::PROTOCOL_ERROR_LENGTH;
    end else if (!cmd_q.is_rd && (idx_q != 2'd3 || pl_cnt_q != cmd_q.len)) begin
      err_d = recovery_pkg::PROTOCOL_ERROR_LENGTH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q       <= '0;
      pl_cnt_q    <= '0;
      open_q      <= 1'b0;
      busy_q      <= 1'b0;
      pl_valid_o  <= 1'b0;
      pl_flush_o  <= 1'b0;
      cmd_valid_o <= 1'b0;
    end else begin
      pl_valid_o  <= take_pl;
      pl_flush_o  <= rx_end_i & open_q;
      // Flush reaches the queue one cycle ahead of the command
      cmd_valid_o <= pl_flush_o;
      if (rx_start_i) begin
        idx_q    <= '0;
        pl_cnt_q <= '0;
        open_q   <= 1'b1;
        busy_q   <= 1'b1;
      end else begin
        if (rx_valid_i && open_q && idx_q != 2'd3) idx_q <= idx_q + 2'd1;
        if (take_pl) pl_cnt_q <= pl_cnt_q + 16'd1;
        if (rx_end_i) open_q <= 1'b0;
        if (cmd_valid_o) busy_q <= 1'b0;
      end
    end
  end

  // Command fields and payload byte
  always_ff @(posedge clk_i) begin
    pl_byte_o <= rx_byte_i;
    if (rx_start_i) begin
      cmd_q.is_rd <= rx_rd_i;
      cmd_q.len   <= '0;
    end else if (rx_valid_i && open_q) begin
      case (idx_q)
        2'd0: cmd_q.cmd <= recovery_pkg::command_e'(rx_byte_i);
        2'd1: if (!cmd_q.is_rd) cmd_q.len[7:0] <= rx_byte_i;
        2'd2: if (!cmd_q.is_rd) cmd_q.len[15:8] <= rx_byte_i;
        default: ;
      endcase
    end
    if (rx_end_i && open_q) cmd_q.err <= err_d;
  end

  // Bus layer holds off new frames until the executor has finished
  assert property (@(posedge clk_i) disable iff (!rst_ni) rx_start_i |-> !busy_q)
    else $error("frame started while a command is outstanding");

endmodule

// ==== design/recovery_rx_queue.sv ====
// Payload queue that packs bytes into words and returns one word per request
`timescale 1ns/1ps

module recovery_rx_queue #(
  parameter int unsigned RX_QUEUE_DEPTH = 8
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                pl_valid_i,
  input  recovery_pkg::byte_t pl_byte_i,
  input  logic                pl_flush_i,
  input  logic                rx_req_i,
  input  logic                rx_clr_i,
  output logic                rx_ack_o,
  output recovery_pkg::word_t rx_data_o
);

  localparam int unsigned PtrW = (RX_QUEUE_DEPTH > 1) ? $clog2(RX_QUEUE_DEPTH) : 1;
  localparam logic [PtrW-1:0] LastPtr = PtrW'(RX_QUEUE_DEPTH - 1);

  recovery_pkg::word_t mem_q [RX_QUEUE_DEPTH];
  recovery_pkg::word_t pack_q;
  recovery_pkg::word_t push_word;
  logic [1:0]          pack_cnt_q;
  logic [PtrW-1:0]     wptr_q;
  logic [PtrW-1:0]     rptr_q;
  logic [PtrW:0]       count_q;
  logic                push;

  // Full word on the fourth byte, partial word on flush
  assign push      = (pl_valid_i && pack_cnt_q == 2'd3) || (pl_flush_i && pack_cnt_q != 2'd0);
  assign push_word = pl_valid_i ? {pl_byte_i, pack_q[23:0]} : pack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pack_q     <= '0;
      pack_cnt_q <= '0;
      wptr_q     <= '0;
      rptr_q     <= '0;
      count_q    <= '0;
      rx_ack_o   <= 1'b0;
    end else if (rx_clr_i) begin
      pack_q     <= '0;
      pack_cnt_q <= '0;
      wptr_q     <= '0;
      rptr_q     <= '0;
      count_q    <= '0;
      rx_ack_o   <= 1'b0;
    end else begin
      rx_ack_o <= rx_req_i;
      if (push) begin
        pack_q     <= '0;
        pack_cnt_q <= '0;
        wptr_q     <= (wptr_q == LastPtr) ? '0 : wptr_q + 1'b1;
      end else if (pl_valid_i) begin
        pack_q[8*pack_cnt_q +: 8] <= pl_byte_i;
        pack_cnt_q                <= pack_cnt_q + 2'd1;
      end
      if (rx_req_i) rptr_q <= (rptr_q == LastPtr) ? '0 : rptr_q + 1'b1;
      count_q <= count_q + (PtrW+1)'(push) - (PtrW+1)'(rx_req_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push && !rx_clr_i) mem_q[wptr_q] <= push_word;
    if (rx_req_i) rx_data_o <= mem_q[rptr_q];
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   push |-> count_q < (PtrW+1)'(RX_QUEUE_DEPTH))
    else $error("payload queue overflow");

endmodule

// ==== design/recovery_executor.sv ====
// Command executor FSM that runs one command against the recovery registers
`timescale 1ns/1ps

module recovery_executor (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          cmd_valid_i,
  input  recovery_pkg::recovery_cmd_t   cmd_i,
  output logic                          cmd_done_o,
  output logic                          rx_req_o,
  input  logic                          rx_ack_i,
  input  recovery_pkg::word_t           rx_data_i,
  output logic                          rx_clr_o,
  output recovery_pkg::csr_e            csr_sel_o,
  output logic                          csr_we_o,
  output recovery_pkg::word_t           csr_wdata_o,
  input  recovery_pkg::word_t           csr_rdata_i,
  output logic                          status_we_o,
  output recovery_pkg::protocol_error_e status_code_o,
  output logic                          payload_set_o,
  output logic                          res_valid_o,
  output recovery_pkg::len_t            res_len_o,
  input  logic                          res_dready_i,
  output logic                          res_dvalid_o,
  output recovery_pkg::byte_t           res_data_o,
  output logic                          res_dlast_o
);

  typedef enum logic [2:0] {
    Idle,
    CsrWrite,
    CsrRead,
    CsrReadData,
    Error,
    Done
  } state_e;

  state_e                        state_q;
  state_e                        state_d;
  recovery_pkg::csr_e            csr_sel_q;
  recovery_pkg::csr_e            start_sel;
  recovery_pkg::protocol_error_e status_q;
  recovery_pkg::protocol_error_e start_status;
  // Words left on a write, bytes left on a read
  recovery_pkg::len_t            cnt_q;
  recovery_pkg::len_t            words;
  logic [1:0]                    bcnt_q;
  logic                          wr_en_q;
  logic                          ff_data_q;
  logic                          wait_q;
  logic                          known;
  logic                          reg_wr;
  logic                          beat;

  assign words = (cmd_i.len >> 2) + recovery_pkg::len_t'(|cmd_i.len[1:0]);
  assign beat  = res_dvalid_o & res_dready_i;

  // Command decode
  always_comb begin
    start_sel = recovery_pkg::CSR_INVALID;
    known     = 1'b1;
    reg_wr    = 1'b0;
    case (cmd_i.cmd)
      recovery_pkg::CMD_PROT_CAP:           start_sel = recovery_pkg::CSR_PROT_CAP_0;
      recovery_pkg::CMD_DEVICE_STATUS:      start_sel = recovery_pkg::CSR_DEVICE_STATUS;
      recovery_pkg::CMD_RECOVERY_STATUS:    start_sel = recovery_pkg::CSR_RECOVERY_STATUS;
      recovery_pkg::CMD_INDIRECT_FIFO_DATA: start_sel = recovery_pkg::CSR_FIFO_DATA;
      recovery_pkg::CMD_DEVICE_RESET: begin
        start_sel = recovery_pkg::CSR_DEVICE_RESET;
        reg_wr    = 1'b1;
      end
      recovery_pkg::CMD_RECOVERY_CTRL: begin
        start_sel = recovery_pkg::CSR_RECOVERY_CTRL;
        reg_wr    = 1'b1;
      end
      default: known = 1'b0;
    endcase
    if (cmd_i.err != recovery_pkg::PROTOCOL_OK) begin
      start_status = cmd_i.err;
    end else if (!known) begin
      start_status = recovery_pkg::PROTOCOL_ERROR_PARAMETER;
    end else if (!cmd_i.is_rd && !reg_wr && start_sel != recovery_pkg::CSR_FIFO_DATA) begin
      start_status = recovery_pkg::PROTOCOL_ERROR_READ_ONLY;
    end else begin
      start_status = recovery_pkg::PROTOCOL_OK;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (cmd_valid_i) begin
          if (cmd_i.err != recovery_pkg::PROTOCOL_OK || !known) state_d = Error;
          else if (cmd_i.is_rd) state_d = CsrRead;
          else if (words == '0) state_d = Done;
          else state_d = CsrWrite;
        end
      end
      CsrWrite:    if (rx_ack_i && cnt_q == 16'd1) state_d = Done;
      CsrRead:     state_d = CsrReadData;
      CsrReadData: if (beat && cnt_q == 16'd1) state_d = Done;
      Error:       state_d = Done;
      default:     state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= Idle;
      csr_sel_q <= recovery_pkg::CSR_INVALID;
      status_q  <= recovery_pkg::PROTOCOL_OK;
      cnt_q     <= '0;
      bcnt_q    <= '0;
      wr_en_q   <= 1'b0;
      ff_data_q <= 1'b0;
      wait_q    <= 1'b0;
      rx_req_o  <= 1'b0;
    end else begin
      state_q  <= state_d;
      rx_req_o <= 1'b0;
      wait_q   <= 1'b0;
      case (state_q)
        Idle: if (cmd_valid_i) begin
          csr_sel_q <= start_sel;
          status_q  <= start_status;
          cnt_q     <= cmd_i.is_rd ? recovery_pkg::cmd_length(cmd_i.cmd) : words;
          bcnt_q    <= '0;
          wr_en_q   <= ~cmd_i.is_rd & reg_wr;
          ff_data_q <= ~cmd_i.is_rd & (start_sel == recovery_pkg::CSR_FIFO_DATA);
          rx_req_o  <= ~cmd_i.is_rd & known & (words != '0) &
                       (cmd_i.err == recovery_pkg::PROTOCOL_OK);
        end
        CsrWrite: if (rx_ack_i) begin
          // Writable registers are one word wide and later words are only drained
          cnt_q    <= cnt_q - 16'd1;
          wr_en_q  <= 1'b0;
          rx_req_o <= (cnt_q != 16'd1);
        end
        CsrReadData: if (beat) begin
          cnt_q  <= cnt_q - 16'd1;
          bcnt_q <= bcnt_q + 2'd1;
          if (bcnt_q == 2'd3 && cnt_q != 16'd1) begin
            // Read data of the next word lags the select by a cycle
            csr_sel_q <= recovery_pkg::csr_e'(csr_sel_q + 4'd1);
            wait_q    <= 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  assign csr_sel_o     = csr_sel_q;
  assign csr_we_o      = (state_q == CsrWrite) & rx_ack_i & wr_en_q;
  assign csr_wdata_o   = rx_data_i;
  assign rx_clr_o      = (state_q == Error);
  assign status_we_o   = (state_q == Done);
  assign status_code_o = status_q;
  assign payload_set_o = (state_q == Done) & ff_data_q & (status_q == recovery_pkg::PROTOCOL_OK);
  assign cmd_done_o    = (state_q == Done);

  // Response length still holds the full byte count while in CsrRead
  assign res_valid_o  = (state_q == CsrRead);
  assign res_len_o    = cnt_q;
  assign res_dvalid_o = (state_q == CsrReadData) & ~wait_q;
  assign res_data_o   = csr_rdata_i[8*bcnt_q +: 8];
  assign res_dlast_o  = res_dvalid_o & (cnt_q == 16'd1);

  // Register writes only land on writable words
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   csr_we_o |-> (csr_sel_o == recovery_pkg::CSR_DEVICE_RESET ||
                                 csr_sel_o == recovery_pkg::CSR_RECOVERY_CTRL))
    else $error("register write to a read-only word");

endmodule

// ==== design/recovery_csr_file.sv ====
// Recovery register file with registered read mux, status byte and payload flag
`timescale 1ns/1ps

module recovery_csr_file #(
  parameter logic [63:0] PROT_CAP_VALUE = '0
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  recovery_pkg::csr_e            csr_sel_i,
  input  logic                          csr_we_i,
  input  recovery_pkg::word_t           csr_wdata_i,
  input  logic                          status_we_i,
  input  recovery_pkg::protocol_error_e status_code_i,
  input  logic                          payload_set_i,
  input  logic                          payload_ack_i,
  input  recovery_pkg::word_t           recovery_status_i,
  output recovery_pkg::word_t           csr_rdata_o,
  output logic                          payload_available_o,
  output logic                          image_activated_o,
  output recovery_pkg::word_t           reset_ctrl_o
);

  // DEVICE_RESET and RECOVERY_CTRL hold three bytes
  localparam recovery_pkg::word_t WriteMask = 32'h00FF_FFFF;

  recovery_pkg::word_t           reset_q;
  recovery_pkg::word_t           ctrl_q;
  recovery_pkg::protocol_error_e status_q;
  logic                          avail_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reset_q  <= '0;
      ctrl_q   <= '0;
      status_q <= recovery_pkg::PROTOCOL_OK;
      avail_q  <= 1'b0;
    end else begin
      if (csr_we_i && csr_sel_i == recovery_pkg::CSR_DEVICE_RESET) begin
        reset_q <= csr_wdata_i & WriteMask;
      end
      if (csr_we_i && csr_sel_i == recovery_pkg::CSR_RECOVERY_CTRL) begin
        ctrl_q <= csr_wdata_i & WriteMask;
      end
      if (status_we_i) status_q <= status_code_i;
      // New payload wins over an ack in the same cycle
      if (payload_set_i) avail_q <= 1'b1;
      else if (payload_ack_i) avail_q <= 1'b0;
    end
  end

  // Read mux
  always_ff @(posedge clk_i) begin
    case (csr_sel_i)
      recovery_pkg::CSR_PROT_CAP_0:      csr_rdata_o <= PROT_CAP_VALUE[31:0];
      recovery_pkg::CSR_PROT_CAP_1:      csr_rdata_o <= PROT_CAP_VALUE[63:32];
      recovery_pkg::CSR_DEVICE_STATUS:   csr_rdata_o <= {16'h0, status_q, 8'h0};
      recovery_pkg::CSR_DEVICE_RESET:    csr_rdata_o <= reset_q;
      recovery_pkg::CSR_RECOVERY_CTRL:   csr_rdata_o <= ctrl_q;
      recovery_pkg::CSR_RECOVERY_STATUS: csr_rdata_o <= {16'h0, recovery_status_i[15:0]};
      default:                           csr_rdata_o <= '0;
    endcase
  end

  assign payload_available_o = avail_q;
  assign image_activated_o   = (ctrl_q[23:16] == 8'h0F);
  assign reset_ctrl_o        = reset_q;

endmodule

// ==== design/recovery_tx_framer.sv ====
// Response framer that sends the two length bytes and then the data bytes
`timescale 1ns/1ps

module recovery_tx_framer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                res_valid_i,
  input  recovery_pkg::len_t  res_len_i,
  input  logic                res_dvalid_i,
  input  recovery_pkg::byte_t res_data_i,
  input  logic                res_dlast_i,
  input  logic                tx_ready_i,
  output logic                res_dready_o,
  output logic                tx_valid_o,
  output recovery_pkg::byte_t tx_byte_o,
  output logic                tx_last_o
);

  typedef enum logic [1:0] {
    PhIdle,
    PhLenLo,
    PhLenHi,
    PhData
  } phase_e;

  phase_e             phase_q;
  recovery_pkg::len_t len_q;
  logic               hs;

  assign tx_valid_o   = (phase_q == PhLenLo) | (phase_q == PhLenHi) |
                        ((phase_q == PhData) & res_dvalid_i);
  assign tx_byte_o    = (phase_q == PhLenLo) ? len_q[7:0] :
                        (phase_q == PhLenHi) ? len_q[15:8] : res_data_i;
  assign tx_last_o    = tx_valid_o & (phase_q == PhData) & res_dlast_i;
  assign res_dready_o = (phase_q == PhData) & tx_ready_i;
  assign hs           = tx_valid_o & tx_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= PhIdle;
    end else begin
      case (phase_q)
        PhIdle:  if (res_valid_i) phase_q <= PhLenLo;
        PhLenLo: if (hs) phase_q <= PhLenHi;
        PhLenHi: if (hs) phase_q <= PhData;
        PhData:  if (hs && res_dlast_i) phase_q <= PhIdle;
        default: phase_q <= PhIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_valid_i) len_q <= res_len_i;
  end

  // A stalled byte stays put, including data held by the executor
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_byte_o))
    else $error("tx byte changed while stalled");

endmodule

// ==== design/recovery_top.sv ====
// Recovery command layer top level connecting parser, queue, executor, registers and framer
`timescale 1ns/1ps

module recovery_top #(
  parameter logic [63:0] PROT_CAP_VALUE = 64'h0123_4567_89AB_CDEF,
  parameter int unsigned RX_QUEUE_DEPTH = 8
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                rx_start_i,
  input  logic                rx_rd_i,
  input  logic                rx_valid_i,
  input  recovery_pkg::byte_t rx_byte_i,
  input  logic                rx_end_i,
  input  logic                rx_pec_err_i,
  input  logic                tx_ready_i,
  output logic                tx_valid_o,
  output recovery_pkg::byte_t tx_byte_o,
  output logic                tx_last_o,
  input  recovery_pkg::word_t recovery_status_i,
  input  logic                payload_ack_i,
  output logic                payload_available_o,
  output logic                image_activated_o,
  output recovery_pkg::word_t reset_ctrl_o,
  output logic                cmd_done_o
);

  logic                          cmd_valid;
  recovery_pkg::recovery_cmd_t   cmd;
  logic                          pl_valid;
  recovery_pkg::byte_t           pl_byte;
  logic                          pl_flush;
  logic                          rx_req;
  logic                          rx_ack;
  logic                          rx_clr;
  recovery_pkg::word_t           rx_data;
  recovery_pkg::csr_e            csr_sel;
  logic                          csr_we;
  recovery_pkg::word_t           csr_wdata;
  recovery_pkg::word_t           csr_rdata;
  logic                          status_we;
  recovery_pkg::protocol_error_e status_code;
  logic                          payload_set;
  logic                          res_valid;
  recovery_pkg::len_t            res_len;
  logic                          res_dready;
  logic                          res_dvalid;
  recovery_pkg::byte_t           res_data;
  logic                          res_dlast;

  recovery_cmd_parser u_parser (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rx_start_i   (rx_start_i),
    .rx_rd_i      (rx_rd_i),
    .rx_valid_i   (rx_valid_i),
    .rx_byte_i    (rx_byte_i),
    .rx_end_i     (rx_end_i),
    .rx_pec_err_i (rx_pec_err_i),
    .cmd_valid_o  (cmd_valid),
    .cmd_o        (cmd),
    .pl_valid_o   (pl_valid),
    .pl_byte_o    (pl_byte),
    .pl_flush_o   (pl_flush)
  );

  recovery_rx_queue #(
    .RX_QUEUE_DEPTH (RX_QUEUE_DEPTH)
  ) u_rx_queue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .pl_valid_i (pl_valid),
    .pl_byte_i  (pl_byte),
    .pl_flush_i (pl_flush),
    .rx_req_i   (rx_req),
    .rx_clr_i   (rx_clr),
    .rx_ack_o   (rx_ack),
    .rx_data_o  (rx_data)
  );

  recovery_executor u_executor (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_valid_i   (cmd_valid),
    .cmd_i         (cmd),
    .cmd_done_o    (cmd_done_o),
    .rx_req_o      (rx_req),
    .rx_ack_i      (rx_ack),
    .rx_data_i     (rx_data),
    .rx_clr_o      (rx_clr),
    .csr_sel_o     (csr_sel),
    .csr_we_o      (csr_we),
    .csr_wdata_o   (csr_wdata),
    .csr_rdata_i   (csr_rdata),
    .status_we_o   (status_we),
    .status_code_o (status_code),
    .payload_set_o (payload_set),
    .res_valid_o   (res_valid),
    .res_len_o     (res_len),
    .res_dready_i  (res_dready),
    .res_dvalid_o  (res_dvalid),
    .res_data_o    (res_data),
    .res_dlast_o   (res_dlast)
  );

  recovery_csr_file #(
    .PROT_CAP_VALUE (PROT_CAP_VALUE)
  ) u_csr_file (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .csr_sel_i           (csr_sel),
    .csr_we_i            (csr_we),
    .csr_wdata_i         (csr_wdata),
    .status_we_i         (status_we),
    .status_code_i       (status_code),
    .payload_set_i       (payload_set),
    .payload_ack_i       (payload_ack_i),
    .recovery_status_i   (recovery_status_i),
    .csr_rdata_o         (csr_rdata),
    .payload_available_o (payload_available_o),
    .image_activated_o   (image_activated_o),
    .reset_ctrl_o        (reset_ctrl_o)
  );

  recovery_tx_framer u_tx_framer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .res_valid_i  (res_valid),
    .res_len_i    (res_len),
    .res_dvalid_i (res_dvalid),
    .res_data_i   (res_data),
    .res_dlast_i  (res_dlast),
    .tx_ready_i   (tx_ready_i),
    .res_dready_o (res_dready),
    .tx_valid_o   (tx_valid_o),
    .tx_byte_o    (tx_byte_o),
    .tx_last_o    (tx_last_o)
  );

endmodule

// ==== sim/tb_recovery_top.sv ====
// Testbench for the recovery command layer that drives bus frames and checks responses
`timescale 1ns/1ps

module tb_recovery_top;

  localparam logic [63:0] ProtCap  = 64'hFEDC_BA98_7654_3210;
  localparam logic [31:0] RecStat  = 32'hA5C3_5A3C;
  localparam int          MaxWait  = 200;

  logic                clk_i;
  logic                rst_ni;
  logic                rx_start_i;
  logic                rx_rd_i;
  logic                rx_valid_i;
  recovery_pkg::byte_t rx_byte_i;
  logic                rx_end_i;
  logic                rx_pec_err_i;
  logic                tx_ready_i;
  logic                tx_valid_o;
  recovery_pkg::byte_t tx_byte_o;
  logic                tx_last_o;
  recovery_pkg::word_t recovery_status_i;
  logic                payload_ack_i;
  logic                payload_available_o;
  logic                image_activated_o;
  recovery_pkg::word_t reset_ctrl_o;
  logic                cmd_done_o;

  // Expected response bytes filled by the read tasks and consumed on each handshake
  logic [7:0] exp_bytes [256];
  logic       exp_lasts [256];
  logic [7:0] exp_wr;
  logic [7:0] exp_rd;
  logic [7:0] exp_head;
  logic       exp_last_head;
  logic       exp_pending;
  logic       tx_hs;

  int errors;
  int errors_at_start;
  int tests_run;
  int tests_failed;

  recovery_top #(
    .PROT_CAP_VALUE (ProtCap),
    .RX_QUEUE_DEPTH (8)
  ) dut_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .rx_start_i          (rx_start_i),
    .rx_rd_i             (rx_rd_i),
    .rx_valid_i          (rx_valid_i),
    .rx_byte_i           (rx_byte_i),
    .rx_end_i            (rx_end_i),
    .rx_pec_err_i        (rx_pec_err_i),
    .tx_ready_i          (tx_ready_i),
    .tx_valid_o          (tx_valid_o),
    .tx_byte_o           (tx_byte_o),
    .tx_last_o           (tx_last_o),
    .recovery_status_i   (recovery_status_i),
    .payload_ack_i       (payload_ack_i),
    .payload_available_o (payload_available_o),
    .image_activated_o   (image_activated_o),
    .reset_ctrl_o        (reset_ctrl_o),
    .cmd_done_o          (cmd_done_o)
  );

  always #50 clk_i = ~clk_i;

  // Random back-pressure from the bus layer
  always @(posedge clk_i) begin
    tx_ready_i <= ($urandom % 4) != 0;
  end

  assign tx_hs         = tx_valid_o & tx_ready_i;
  assign exp_pending   = (exp_rd != exp_wr);
  assign exp_head      = exp_bytes[exp_rd];
  assign exp_last_head = exp_lasts[exp_rd];

  always @(posedge clk_i) begin
    if (rst_ni && tx_hs && exp_pending) exp_rd <= exp_rd + 8'd1;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) tx_hs |-> exp_pending)
    else begin
      errors = errors + 1;
      $display("response byte %02h was sent while none was expected", $sampled(tx_byte_o));
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   tx_hs && exp_pending |-> tx_byte_o == exp_head)
    else begin
      errors = errors + 1;
      $display("mismatch tx_byte_o: got %02h, expected %02h",
               $sampled(tx_byte_o), $sampled(exp_head));
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   tx_hs && exp_pending |-> tx_last_o == exp_last_head)
    else begin
      errors = errors + 1;
      $display("mismatch tx_last_o: got %h, expected %h",
               $sampled(tx_last_o), $sampled(exp_last_head));
    end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else begin
        errors = errors + 1;
        $display("mismatch %s: got %08h, expected %08h", name, got, exp);
      end
  endtask

  task automatic expect_byte(input logic [7:0] b, input logic last);
    exp_bytes[exp_wr] = b;
    exp_lasts[exp_wr] = last;
    exp_wr = exp_wr + 8'd1;
  endtask

  // Returns on the negedge after the done pulse when the status registers have settled
  task automatic wait_done(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!cmd_done_o && cycles < MaxWait) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!cmd_done_o) begin
      errors = errors + 1;
      $display("timed out waiting for cmd_done_o after %s", what);
    end
    @(negedge clk_i);
  endtask

  task automatic send_frame(input logic rd, input logic [7:0] cmd, input logic [15:0] len,
                            input int n, input logic [63:0] data, input logic pec);
    int i;
    @(posedge clk_i);
    rx_start_i <= 1'b1;
    rx_rd_i    <= rd;
    @(posedge clk_i);
    rx_start_i <= 1'b0;
    rx_valid_i <= 1'b1;
    rx_byte_i  <= cmd;
    if (!rd) begin
      @(posedge clk_i);
      rx_byte_i <= len[7:0];
      @(posedge clk_i);
      rx_byte_i <= len[15:8];
      for (i = 0; i < n; i++) begin
        @(posedge clk_i);
        rx_byte_i <= data[8*i +: 8];
      end
    end
    @(posedge clk_i);
    rx_valid_i   <= 1'b0;
    rx_end_i     <= 1'b1;
    rx_pec_err_i <= pec;
    @(posedge clk_i);
    rx_end_i     <= 1'b0;
    rx_pec_err_i <= 1'b0;
    wait_done($sformatf("command %0d", cmd));
  endtask

  task automatic write_reg(input logic [7:0] cmd, input int n, input logic [63:0] data);
    send_frame(1'b0, cmd, 16'(n), n, data, 1'b0);
  endtask

  // Response is the length low and high bytes and then the value least significant first
  task automatic read_reg(input logic [7:0] cmd, input int n, input logic [63:0] value);
    int i;
    expect_byte(8'(n), 1'b0);
    expect_byte(8'(n >> 8), 1'b0);
    for (i = 0; i < n; i++) begin
      expect_byte(value[8*i +: 8], i == n - 1);
    end
    send_frame(1'b1, cmd, 16'h0, 0, 64'h0, 1'b0);
    assert (exp_rd == exp_wr)
      else begin
        errors = errors + 1;
        $display("read of command %0d ended before all response bytes were sent", cmd);
      end
  endtask

  task automatic pulse_payload_ack();
    @(posedge clk_i);
    payload_ack_i <= 1'b1;
    @(posedge clk_i);
    payload_ack_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic start_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - errors_at_start);
    end else begin
      $display("test %0d %s: passed", tests_run, name);
    end
  endtask

  initial begin
    void'($urandom(32'h240125d7));
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    rx_start_i        = 1'b0;
    rx_rd_i           = 1'b0;
    rx_valid_i        = 1'b0;
    rx_byte_i         = '0;
    rx_end_i          = 1'b0;
    rx_pec_err_i      = 1'b0;
    tx_ready_i        = 1'b0;
    recovery_status_i = RecStat;
    payload_ack_i     = 1'b0;
    exp_wr            = '0;
    exp_rd            = '0;
    errors            = 0;
    tests_run         = 0;
    tests_failed      = 0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    start_test();
    read_reg(8'd34, 8, ProtCap);
    end_test("PROT_CAP read");

    start_test();
    write_reg(8'd38, 3, 64'h0F_2211);
    check_value("image_activated_o", 32'(image_activated_o), 32'h1);
    // Status of the write itself, before a read overwrites it
    read_reg(8'd36, 4, 64'h0);
    read_reg(8'd38, 3, 64'h0F_2211);
    end_test("RECOVERY_CTRL write and readback");

    start_test();
    write_reg(8'd39, 2, 64'hBEEF);
    read_reg(8'd36, 4, 64'h0100);
    read_reg(8'd39, 2, 64'(RecStat[15:0]));
    end_test("RECOVERY_STATUS read only");

    start_test();
    write_reg(8'd37, 3, 64'h03_0201);
    check_value("reset_ctrl_o", reset_ctrl_o, 32'h0003_0201);
    send_frame(1'b0, 8'd37, 16'd3, 3, 64'hCC_BBAA, 1'b1);
    check_value("reset_ctrl_o", reset_ctrl_o, 32'h0003_0201);
    read_reg(8'd36, 4, 64'h0400);
    // Three bytes declared but only two sent
    send_frame(1'b0, 8'd37, 16'd3, 2, 64'hBBAA, 1'b0);
    check_value("reset_ctrl_o", reset_ctrl_o, 32'h0003_0201);
    read_reg(8'd36, 4, 64'h0300);
    write_reg(8'd37, 3, 64'h33_2211);
    check_value("reset_ctrl_o", reset_ctrl_o, 32'h0033_2211);
    read_reg(8'd37, 3, 64'h33_2211);
    end_test("CRC and length errors");

    start_test();
    write_reg(8'd47, 8, 64'h8877_6655_4433_2211);
    check_value("payload_available_o", 32'(payload_available_o), 32'h1);
    read_reg(8'd36, 4, 64'h0);
    pulse_payload_ack();
    check_value("payload_available_o", 32'(payload_available_o), 32'h0);
    write_reg(8'h55, 4, 64'hDEAD_BEEF);
    read_reg(8'd36, 4, 64'h0200);
    check_value("payload_available_o", 32'(payload_available_o), 32'h0);
    end_test("payload flag and unknown command");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
design/recovery_pkg.sv
design/recovery_cmd_parser.sv
design/recovery_rx_queue.sv
design/recovery_executor.sv
design/recovery_csr_file.sv
design/recovery_tx_framer.sv
design/recovery_top.sv
sim/tb_recovery_top.sv
